/* files.f */
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_ifs.sv
hdl/icache_req_stage.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_ctrl.sv
hdl/icache_refill.sv
hdl/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    output logic        addr_ok,
    output logic        data_ok,
    output logic        rd_req,
    icache_req_if.ctrl  req_io,
    icache_fill_if.ctrl fill_io
);

    icache_state_e state_q;
    icache_state_e state_d;
    logic          lookup_hit;

    assign lookup_hit = (state_q == lookup) && fill_io.hit;

    // a hit frees the front end for the next request at once
    assign addr_ok = (state_q == idle) || lookup_hit;
    assign data_ok = lookup_hit || (state_q == refill);

    assign req_io.capture = valid && addr_ok;

    // memory read goes out right after the missed lookup;
    // replace waits for the captured line to settle
    assign rd_req = (state_q == miss);

    // tag and data of the victim way are written at the end of refill
    assign fill_io.fill = (state_q == refill);

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (valid) begin
                    state_d = lookup;
                end
            end
            lookup: begin
                if (!fill_io.hit) begin
                    state_d = miss;
                end else if (valid) begin
                    state_d = lookup;
                end else begin
                    state_d = idle;
                end
            end
            miss: begin
                state_d = replace;
            end
            replace: begin
                state_d = refill;
            end
            refill: begin
                state_d = idle;
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* hdl/icache_data_array.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_data_array (
    input  logic                      clk,
    input  logic                      rst,
    output logic [`ICACHE_WORD_W-1:0] hit_word,
    icache_req_if.sink                req_io,
    icache_fill_if.data               fill_io
);

    localparam int ENTRY_W = 2 * `ICACHE_LINE_W;

    // way 1 in the upper half, way 0 in the lower half
    logic [ENTRY_W-1:0]             mem [`ICACHE_SETS];
    logic [ENTRY_W-1:0]             q_q;
    logic [ENTRY_W-1:0]             wmask;
    logic [ENTRY_W-1:0]             wdata;
    logic [`ICACHE_INDEX_W-1:0]     ram_addr;
    logic [`ICACHE_LINE_W-1:0]      way_data;

    // refill writes the buffered set, a new request reads the live one
    assign ram_addr = fill_io.fill ? req_io.req.index : req_io.cur.index;

    assign wdata = {fill_io.line, fill_io.line};
    assign wmask = fill_io.victim_way ? {{`ICACHE_LINE_W{1'b1}}, {`ICACHE_LINE_W{1'b0}}}
                                      : {{`ICACHE_LINE_W{1'b0}}, {`ICACHE_LINE_W{1'b1}}};

    always_ff @(posedge clk) begin
        if (fill_io.fill) begin
            mem[ram_addr] <= (mem[ram_addr] & ~wmask) | (wdata & wmask);
        end
    end

    // output holds between captures, read back in lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            q_q <= '0;
        end else if (req_io.capture) begin
            q_q <= mem[ram_addr];
        end
    end

    assign way_data = fill_io.hit_way ? q_q[ENTRY_W-1:`ICACHE_LINE_W]
                                      : q_q[`ICACHE_LINE_W-1:0];

    // offset bit 2 picks the word within the line
    assign hit_word = req_io.req.offset[2] ? way_data[`ICACHE_LINE_W-1:`ICACHE_WORD_W]
                                           : way_data[`ICACHE_WORD_W-1:0];

endmodule

/* hdl/icache_ifs.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

// request fields from the input side
interface icache_req_if import icache_pkg::*; ();
    // fields of the address on the pipeline right now
    icache_req_t cur;
    // buffered copy of the accepted request
    icache_req_t req;
    logic        capture;

    modport src (
        output cur,
        output req,
        input  capture
    );

    modport ctrl (
        output capture
    );

    modport sink (
        input cur,
        input req,
        input capture
    );
endinterface

// refill line, way choice and hit result
interface icache_fill_if ();
    logic [`ICACHE_LINE_W-1:0] line;
    logic                      fill;
    logic                      victim_way;
    logic                      hit;
    logic                      hit_way;

    modport refill (
        output line,
        input  fill
    );

    modport ctrl (
        output fill,
        input  hit
    );

    modport tags (
        output victim_way,
        output hit,
        output hit_way,
        input  fill
    );

    modport data (
        input line,
        input fill,
        input victim_way,
        input hit_way
    );
endinterface

/* hdl/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address fields, tag | index | offset
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

// one entry per set, two ways
`define ICACHE_SETS     64

// a line holds two instruction words
`define ICACHE_LINE_W   64
`define ICACHE_WORD_W   32

`endif

/* hdl/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

    // controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } icache_state_e;

    // fetch address split into its cache fields
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } icache_req_t;

endpackage

/* hdl/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_refill (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_req,
    input  logic [`ICACHE_LINE_W-1:0] ret_data,
    input  logic [`ICACHE_WORD_W-1:0] hit_word,
    output logic [31:0]               rd_addr,
    output logic [`ICACHE_WORD_W-1:0] rdata,
    icache_req_if.sink                req_io,
    icache_fill_if.refill             fill_io
);

    logic [`ICACHE_LINE_W-1:0] line_q;
    logic [`ICACHE_WORD_W-1:0] line_word;

    // line address of the buffered request
    assign rd_addr = {req_io.req.tag, req_io.req.index, {`ICACHE_OFFSET_W{1'b0}}};

    // memory answers in the request cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (rd_req) begin
            line_q <= ret_data;
        end
    end

    assign fill_io.line = line_q;

    assign line_word = req_io.req.offset[2] ? line_q[`ICACHE_LINE_W-1:`ICACHE_WORD_W]
                                            : line_q[`ICACHE_WORD_W-1:0];

    // refill serves straight from the line buffer, RAM is written same edge
    assign rdata = fill_io.fill ? line_word : hit_word;

endmodule

/* hdl/icache_req_stage.sv */
`timescale 1ns/1ps

module icache_req_stage
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    input  logic [31:0] addr,
    icache_req_if.src   req_io
);

    icache_req_t req_q;

    // split the live address so the RAM can be addressed this cycle
    assign req_io.cur = addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (req_io.capture) begin
            req_q <= req_io.cur;
        end
    end

    // buffered copy drives tag compare, word select and miss address
    assign req_io.req = req_q;

endmodule

/* hdl/icache_tag_array.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tag_array (
    input  logic       clk,
    input  logic       rst,
    icache_req_if.sink req_io,
    icache_fill_if.tags fill_io
);

    logic [`ICACHE_SETS-1:0]  valid_q [2];
    logic [`ICACHE_TAG_W-1:0] tag_q   [2][`ICACHE_SETS];
    logic [1:0]               way_hit;
    logic                     victim_q;
    logic [`ICACHE_INDEX_W-1:0] idx;

    assign idx = req_io.req.index;

    // compare both ways against the buffered tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == req_io.req.tag);
        end
    end

    assign fill_io.hit     = |way_hit;
    assign fill_io.hit_way = way_hit[1];

    // free-running toggle as pseudo-random victim
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_q <= 1'b0;
        end else begin
            victim_q <= ~victim_q;
        end
    end

    assign fill_io.victim_way = victim_q;

    // valid bits start cleared so every set misses first
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (fill_io.fill) begin
            valid_q[victim_q][idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_io.fill) begin
            tag_q[victim_q][idx] <= req_io.req.tag;
        end
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    // pipeline side
    input  logic                      valid,
    input  logic [31:0]               addr,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [`ICACHE_WORD_W-1:0] rdata,
    // memory side
    output logic                      rd_req,
    output logic [31:0]               rd_addr,
    input  logic [`ICACHE_LINE_W-1:0] ret_data
);

    logic [`ICACHE_WORD_W-1:0] hit_word;

    icache_req_if  req_if ();
    icache_fill_if fill_if ();

    icache_req_stage u_req_stage (
        .clk    (clk),
        .rst    (rst),
        .valid  (valid),
        .addr   (addr),
        .req_io (req_if.src)
    );

    icache_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .valid   (valid),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rd_req  (rd_req),
        .req_io  (req_if.ctrl),
        .fill_io (fill_if.ctrl)
    );

    icache_tag_array u_tag_array (
        .clk     (clk),
        .rst     (rst),
        .req_io  (req_if.sink),
        .fill_io (fill_if.tags)
    );

    icache_data_array u_data_array (
        .clk      (clk),
        .rst      (rst),
        .hit_word (hit_word),
        .req_io   (req_if.sink),
        .fill_io  (fill_if.data)
    );

    icache_refill u_refill (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (rd_req),
        .ret_data (ret_data),
        .hit_word (hit_word),
        .rd_addr  (rd_addr),
        .rdata    (rdata),
        .req_io   (req_if.sink),
        .fill_io  (fill_if.refill)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -u
cd "$(dirname "$0")"

TOP=icache_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f files.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

/* verification/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    localparam int NUM_RANDOM     = 370;
    localparam int NUM_DIRECTED   = 5;
    localparam int TIMEOUT_CYCLES = 400 * 6 + 100;
    localparam int DRIVE_DELAY    = 1;

    typedef struct packed {
        logic [31:0] addr;
        int          accept_cycle;
        logic        must_hit;
    } fetch_rec_t;

    logic        clk;
    logic        rst;
    logic        valid;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic [63:0] ret_data;

    integer      seed = 32'hdb5679ab;
    int          errors = 0;
    int          cycle_count = 0;
    int          hits = 0;
    int          misses = 0;
    int          must_hit_seen = 0;
    int          back_to_back = 0;
    int          last_accept = -10;
    fetch_rec_t  pending [$];
    fetch_rec_t  rec;
    bit          head_missed = 1'b0;
    // line last refilled per set, a later fetch of it must hit
    logic [28:0] last_fill [64];
    bit          fill_valid [64];
    // four tags per set over two ways forces evictions
    logic [22:0] tag_pool [4] = '{23'h000a1, 23'h12345, 23'h3c0de, 23'h7ffff};
    logic [5:0]  index_pool [4] = '{6'h00, 6'h15, 6'h2a, 6'h3f};

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    icache_top uut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .addr     (addr),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    // memory content, upper word scrambled
    function automatic logic [63:0] mem_line(input logic [31:0] line_addr);
        return {line_addr ^ 32'h5a5a5a5a, line_addr};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [63:0] line;
        line = mem_line({a[31:3], 3'b000});
        return a[2] ? line[63:32] : line[31:0];
    endfunction

    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = $random(seed);
        return {tag_pool[r[1:0]], index_pool[r[3:2]], r[4], 2'b00};
    endfunction

    // memory answers in the cycle of the request
    assign ret_data = mem_line(rd_addr);

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("at %0t: %s", $time, what);
        errors++;
    endtask

    // called just after an edge, returns just after the accepting edge
    task automatic fetch(input logic [31:0] a);
        valid = 1'b1;
        addr  = a;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic pause();
        valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // monitor samples mid-cycle where all outputs are settled
    always @(negedge clk) begin
        cycle_count++;
        if (!rst) begin
            if (data_ok) begin
                if (pending.size() == 0) begin
                    report_failure("data_ok with no request outstanding");
                end else begin
                    rec = pending.pop_front();
                    check_value("rdata", expected_word(rec.addr), rdata);
                    check_value("data_ok latency", head_missed ? 32'd4 : 32'd1,
                                cycle_count - rec.accept_cycle);
                    if (rec.must_hit) begin
                        must_hit_seen++;
                        if (head_missed) begin
                            report_failure("refetch of a just refilled line missed");
                        end
                    end
                    if (head_missed) begin
                        misses++;
                    end else begin
                        hits++;
                    end
                    head_missed = 1'b0;
                end
            end else if (pending.size() != 0 && cycle_count - pending[0].accept_cycle > 4) begin
                report_failure("no data_ok within 4 cycles of acceptance");
                rec = pending.pop_front();
                head_missed = 1'b0;
            end
            if (rd_req) begin
                if (pending.size() == 0 || head_missed) begin
                    report_failure("rd_req without a new missed request");
                end else begin
                    check_value("rd_req latency", 32'd2, cycle_count - pending[0].accept_cycle);
                    check_value("rd_addr", {pending[0].addr[31:3], 3'b000}, rd_addr);
                    last_fill[pending[0].addr[8:3]] = pending[0].addr[31:3];
                    fill_valid[pending[0].addr[8:3]] = 1'b1;
                    head_missed = 1'b1;
                end
            end
            if (valid && addr_ok) begin
                rec.addr = addr;
                rec.accept_cycle = cycle_count;
                rec.must_hit = fill_valid[addr[8:3]] && (last_fill[addr[8:3]] == addr[31:3]);
                if (last_accept == cycle_count - 1) begin
                    back_to_back++;
                end
                last_accept = cycle_count;
                pending.push_back(rec);
            end
        end
    end

    initial begin
        logic [31:0] base;
        valid = 1'b0;
        addr  = '0;
        wait (rst === 1'b0);
        @(negedge clk);
        check_value("addr_ok", 32'd1, {31'd0, addr_ok});
        check_value("data_ok", 32'd0, {31'd0, data_ok});
        check_value("rd_req", 32'd0, {31'd0, rd_req});
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            fetch(random_addr());
            if (($random(seed) & 3) == 0) begin
                pause();
            end
        end
        // fresh lines, refill then repeats of both words with valid held high
        for (int k = 0; k < NUM_DIRECTED; k++) begin
            base = {20'hf0000, 3'(k), index_pool[k[1:0]], 3'b000};
            fetch(base);
            fetch(base);
            fetch(base | 32'd4);
            fetch(base);
            fetch(base | 32'd4);
            fetch(base);
            pause();
        end
        valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (3) @(posedge clk);
        if (hits == 0 || misses == 0) begin
            report_failure("run saw no hits or no misses");
        end
        if (back_to_back == 0) begin
            report_failure("no requests accepted on consecutive cycles");
        end
        if (must_hit_seen == 0) begin
            report_failure("no refetch right after a refill was made");
        end
        $display("%0d errors, %0d hits, %0d misses", errors, hits, misses);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, %0d errors so far", TIMEOUT_CYCLES, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release reset just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule
